//--- source/ft_alu_pkg.sv
/*
 * shared definitions for the fault-tolerant ALU
 * opcodes, widths, error counter limits and the CSR map
 */
`default_nettype none

package ft_alu_pkg;

	////////////////////
	// datapath sizes
	////////////////////

	// operand and result width
	localparam int DATA_W = 32;
	// physical replicas, one of them is the spare
	localparam int NUM_REPLICAS = 4;
	// lanes seen by the voter
	localparam int NUM_LANES = 3;
	// enough to name any replica
	localparam int REPLICA_IDX_W = 2;

	////////////////////
	// error counters
	////////////////////

	// counters saturate at all ones
	localparam int CNT_W = 8;
	// count at which a replica is marked permanently faulty
	localparam logic [CNT_W-1:0] PERM_THRESHOLD = 8'd8;

	////////////////////
	// CSR map
	////////////////////

	localparam int CSR_ADDR_W = 12;
	// one error counter per replica, word aligned
	localparam logic [CSR_ADDR_W-1:0] CSR_CNT0_ADDR = 12'h000;
	localparam logic [CSR_ADDR_W-1:0] CSR_CNT1_ADDR = 12'h004;
	localparam logic [CSR_ADDR_W-1:0] CSR_CNT2_ADDR = 12'h008;
	localparam logic [CSR_ADDR_W-1:0] CSR_CNT3_ADDR = 12'h00C;
	// permanent flags in bits 3..0
	localparam logic [CSR_ADDR_W-1:0] CSR_STATUS_ADDR = 12'h010;

	// integer subset kept in each replica
	typedef enum logic [3:0] {
		ADD  = 4'd0,
		SUB  = 4'd1,
		AND  = 4'd2,
		OR   = 4'd3,
		XOR  = 4'd4,
		SLL  = 4'd5,
		SRL  = 4'd6,
		SRA  = 4'd7,
		SLT  = 4'd8,
		SLTU = 4'd9,
		EQ   = 4'd10,
		NE   = 4'd11
	} alu_op_e;

	// where the block output is taken from
	typedef enum logic [1:0] {
		BYP_VOTED = 2'd0,
		BYP_LANE1 = 2'd1,
		BYP_LANE2 = 2'd2,
		BYP_LANE3 = 2'd3
	} bypass_e;

endpackage : ft_alu_pkg

`default_nettype wire

//--- source/alu_replica.sv
/*
 * single ALU replica
 * purely combinational, add/sub, logic, shifts and compares
 */
`timescale 1ns/100ps
`default_nettype none

module alu_replica (
	input  wire logic                         enable_i,
	input  wire ft_alu_pkg::alu_op_e          operator_i,
	input  wire logic [ft_alu_pkg::DATA_W-1:0] operand_a_i,
	input  wire logic [ft_alu_pkg::DATA_W-1:0] operand_b_i,
	output logic      [ft_alu_pkg::DATA_W-1:0] result_o,
	output logic                              comparison_result_o
);
	import ft_alu_pkg::*;

	// shift amount, low five bits of b as in RV32
	logic [4:0] shamt;
	assign shamt = operand_b_i[4:0];

	always_comb begin
		result_o = '0;
		comparison_result_o = 1'b0;
		// an idle replica drives zeros on both outputs
		if (enable_i) begin
			case (operator_i)
				ADD: result_o = operand_a_i + operand_b_i;
				SUB: result_o = operand_a_i - operand_b_i;
				AND: result_o = operand_a_i & operand_b_i;
				OR:  result_o = operand_a_i | operand_b_i;
				XOR: result_o = operand_a_i ^ operand_b_i;
				SLL: result_o = operand_a_i << shamt;
				SRL: result_o = operand_a_i >> shamt;
				// arithmetic shift keeps the sign
				SRA: result_o = $signed(operand_a_i) >>> shamt;
				SLT: begin
					comparison_result_o = $signed(operand_a_i) < $signed(operand_b_i);
				end
				SLTU: begin
					comparison_result_o = operand_a_i < operand_b_i;
				end
				EQ: begin
					comparison_result_o = operand_a_i == operand_b_i;
				end
				NE: begin
					comparison_result_o = operand_a_i != operand_b_i;
				end
				default: begin
					result_o = '0;
				end
			endcase
			// compare ops return the bit zero-extended
			if (operator_i inside {SLT, SLTU, EQ, NE}) begin
				result_o = {{(DATA_W-1){1'b0}}, comparison_result_o};
			end
		end
	end

endmodule : alu_replica

`default_nettype wire

//--- source/lane_select.sv
/*
 * lane selection for the voter
 * picks three of four replicas, then optional only-two remap,
 * and reports which replica ends up on every lane
 */
`timescale 1ns/100ps
`default_nettype none

module lane_select (
	input  wire logic [ft_alu_pkg::NUM_REPLICAS-1:0][ft_alu_pkg::DATA_W-1:0] rep_result_i,
	input  wire logic [ft_alu_pkg::NUM_REPLICAS-1:0]                        rep_comp_i,
	input  wire logic [ft_alu_pkg::NUM_LANES-1:0]                           sel_mux_i,
	input  wire logic [1:0]                                                 sel_only_two_i,
	output logic [ft_alu_pkg::NUM_LANES-1:0][ft_alu_pkg::DATA_W-1:0]        lane_result_o,
	output logic [ft_alu_pkg::NUM_LANES-1:0]                                lane_comp_o,
	output logic [ft_alu_pkg::NUM_LANES-1:0][ft_alu_pkg::REPLICA_IDX_W-1:0] lane_src_o
);
	import ft_alu_pkg::*;

	// first level, spare replica or the lane's own one
	logic [NUM_LANES-1:0][DATA_W-1:0]        mux_res;
	logic [NUM_LANES-1:0]                    mux_comp;
	logic [NUM_LANES-1:0][REPLICA_IDX_W-1:0] mux_src;

	////////////////////
	// three of four
	////////////////////

	always_comb begin
		for (int k = 0; k < NUM_LANES; k++) begin
			if (sel_mux_i[k]) begin
				// replica 3 stands in for replica k
				mux_res[k]  = rep_result_i[NUM_REPLICAS-1];
				mux_comp[k] = rep_comp_i[NUM_REPLICAS-1];
				mux_src[k]  = REPLICA_IDX_W'(NUM_REPLICAS-1);
			end else begin
				mux_res[k]  = rep_result_i[k];
				mux_comp[k] = rep_comp_i[k];
				mux_src[k]  = REPLICA_IDX_W'(k);
			end
		end
	end

	////////////////////
	// only-two remap
	////////////////////

	always_comb begin
		// lane 3 always passes straight through
		lane_result_o[2] = mux_res[2];
		lane_comp_o[2]   = mux_comp[2];
		lane_src_o[2]    = mux_src[2];
		// lanes 1 and 2 may borrow lane 3
		for (int k = 0; k < 2; k++) begin
			lane_result_o[k] = sel_only_two_i[k] ? mux_res[2]  : mux_res[k];
			lane_comp_o[k]   = sel_only_two_i[k] ? mux_comp[2] : mux_comp[k];
			lane_src_o[k]    = sel_only_two_i[k] ? mux_src[2]  : mux_src[k];
		end
	end

endmodule : lane_select

`default_nettype wire

//--- source/tmr_voter.sv
/*
 * three-lane majority voter with per-lane mismatch flags
 * in only-two mode lanes 1 and 2 are just compared
 */
`timescale 1ns/100ps
`default_nettype none

module tmr_voter #(
	parameter int WIDTH = 32
) (
	input  wire logic [WIDTH-1:0]                 in_1_i,
	input  wire logic [WIDTH-1:0]                 in_2_i,
	input  wire logic [WIDTH-1:0]                 in_3_i,
	input  wire logic                             only_two_i,
	output logic      [WIDTH-1:0]                 voted_o,
	output logic      [ft_alu_pkg::NUM_LANES-1:0] err_lane_o,
	output logic                                  err_corrected_o,
	output logic                                  err_detected_o
);

	// pairwise agreement
	logic eq_12;
	logic eq_13;
	logic eq_23;

	assign eq_12 = in_1_i == in_2_i;
	assign eq_13 = in_1_i == in_3_i;
	assign eq_23 = in_2_i == in_3_i;

	always_comb begin
		voted_o = in_1_i;
		err_lane_o = 3'b000;
		err_corrected_o = 1'b0;
		if (only_two_i) begin
			// degraded, lane 3 ignored, nothing to correct
			if (!eq_12) begin
				err_lane_o = 3'b011;
			end
		end else if (eq_12 && eq_13) begin
			// all agree
			err_lane_o = 3'b000;
		end else if (eq_12) begin
			// lane 3 outvoted
			err_lane_o = 3'b100;
			err_corrected_o = 1'b1;
		end else if (eq_13) begin
			err_lane_o = 3'b010;
			err_corrected_o = 1'b1;
		end else if (eq_23) begin
			// lane 1 is the odd one, take lane 2
			voted_o = in_2_i;
			err_lane_o = 3'b001;
			err_corrected_o = 1'b1;
		end else begin
			// no majority, lane 1 forwarded as is
			err_lane_o = 3'b111;
		end
		err_detected_o = |err_lane_o;
	end

endmodule : tmr_voter

`default_nettype wire

//--- source/fault_monitor.sv
/*
 * per-replica fault monitor
 * maps lane errors back to replicas, saturating counters,
 * sticky permanent-fault flags
 */
`timescale 1ns/100ps
`default_nettype none

module fault_monitor (
	input  wire logic                                                        clk,
	input  wire logic                                                        reset_i,
	input  wire logic [ft_alu_pkg::NUM_REPLICAS-1:0]                         enable_i,
	input  wire logic [ft_alu_pkg::NUM_LANES-1:0]                            err_lane_res_i,
	input  wire logic [ft_alu_pkg::NUM_LANES-1:0]                            err_lane_comp_i,
	input  wire logic [ft_alu_pkg::NUM_LANES-1:0][ft_alu_pkg::REPLICA_IDX_W-1:0] lane_src_i,
	input  wire logic [ft_alu_pkg::NUM_REPLICAS-1:0]                         clr_i,
	output logic      [ft_alu_pkg::NUM_REPLICAS-1:0][ft_alu_pkg::CNT_W-1:0]  err_count_o,
	output logic      [ft_alu_pkg::NUM_REPLICAS-1:0]                         permanent_faulty_o
);
	import ft_alu_pkg::*;

	// either voter flagged the lane
	logic [NUM_LANES-1:0] lane_err;
	// one error strobe per physical replica
	logic [NUM_REPLICAS-1:0] err_strobe;
	// counter value after this cycle's increment
	logic [NUM_REPLICAS-1:0][CNT_W-1:0] cnt_nxt;

	assign lane_err = err_lane_res_i | err_lane_comp_i;

	////////////////////
	// attribution
	////////////////////

	always_comb begin
		for (int r = 0; r < NUM_REPLICAS; r++) begin
			err_strobe[r] = 1'b0;
			for (int l = 0; l < NUM_LANES; l++) begin
				// lane l was fed by replica r
				if (lane_err[l] && (lane_src_i[l] == REPLICA_IDX_W'(r))) begin
					err_strobe[r] = 1'b1;
				end
			end
			// an idle replica is never blamed
			err_strobe[r] = err_strobe[r] & enable_i[r];
		end
	end

	// saturating increment, sticks at all ones
	always_comb begin
		for (int r = 0; r < NUM_REPLICAS; r++) begin
			cnt_nxt[r] = err_count_o[r];
			if (err_strobe[r] && !(&err_count_o[r])) begin
				cnt_nxt[r] = err_count_o[r] + 1'b1;
			end
		end
	end

	////////////////////
	// counters, flags
	////////////////////

	always_ff @(posedge clk) begin
		for (int r = 0; r < NUM_REPLICAS; r++) begin
			// a CSR clear wins over a same-cycle error
			if (reset_i || clr_i[r]) begin
				err_count_o[r] <= '0;
				permanent_faulty_o[r] <= 1'b0;
			end else begin
				err_count_o[r] <= cnt_nxt[r];
				// flag once the threshold is reached, then hold
				if (cnt_nxt[r] >= PERM_THRESHOLD) begin
					permanent_faulty_o[r] <= 1'b1;
				end
			end
		end
	end

endmodule : fault_monitor

`default_nettype wire

//--- source/ft_csr_apb.sv
/*
 * APB slave for the fault counters
 * zero wait states, read counters or status, write clears a counter
 */
`timescale 1ns/100ps
`default_nettype none

module ft_csr_apb (
	input  wire logic                                                       clk,
	input  wire logic                                                       reset_i,
	input  wire logic                                                       psel_i,
	input  wire logic                                                       penable_i,
	input  wire logic                                                       pwrite_i,
	input  wire logic [ft_alu_pkg::CSR_ADDR_W-1:0]                          paddr_i,
	input  wire logic [ft_alu_pkg::DATA_W-1:0]                              pwdata_i,
	output logic      [ft_alu_pkg::DATA_W-1:0]                              prdata_o,
	input  wire logic [ft_alu_pkg::NUM_REPLICAS-1:0][ft_alu_pkg::CNT_W-1:0] err_count_i,
	input  wire logic [ft_alu_pkg::NUM_REPLICAS-1:0]                        permanent_faulty_i,
	output logic      [ft_alu_pkg::NUM_REPLICAS-1:0]                        clr_o
);
	import ft_alu_pkg::*;

	// setup phase, the transfer is decoded here
	logic setup_ph;
	// read data for the decoded address
	logic [DATA_W-1:0] rd_data;
	// counter addressed by this transfer
	logic [NUM_REPLICAS-1:0] cnt_hit;

	assign setup_ph = psel_i && !penable_i;

	////////////////////
	// address decode
	////////////////////

	always_comb begin
		cnt_hit = '0;
		rd_data = '0;
		case (paddr_i)
			CSR_CNT0_ADDR: cnt_hit[0] = 1'b1;
			CSR_CNT1_ADDR: cnt_hit[1] = 1'b1;
			CSR_CNT2_ADDR: cnt_hit[2] = 1'b1;
			CSR_CNT3_ADDR: cnt_hit[3] = 1'b1;
			CSR_STATUS_ADDR: begin
				rd_data = DATA_W'(permanent_faulty_i);
			end
			// unmapped reads as zero
			default: rd_data = '0;
		endcase
		for (int r = 0; r < NUM_REPLICAS; r++) begin
			if (cnt_hit[r]) begin
				rd_data = DATA_W'(err_count_i[r]);
			end
		end
	end

	// registered at the end of setup, so data and clear sit in the access cycle
	always_ff @(posedge clk) begin
		if (reset_i) begin
			prdata_o <= '0;
			clr_o <= '0;
		end else begin
			clr_o <= '0;
			if (setup_ph && !pwrite_i) begin
				prdata_o <= rd_data;
			end
			// any write to a counter clears it, the data itself is ignored
			if (setup_ph && pwrite_i) begin
				clr_o <= cnt_hit;
			end
		end
	end

endmodule : ft_csr_apb

`default_nettype wire

//--- source/ft_alu_top.sv
/*
 * fault-tolerant ALU top
 * four replicas, lane selection, two voters, bypass,
 * fault monitor and the APB register port
 */
`timescale 1ns/100ps
`default_nettype none

module ft_alu_top (
	input  wire logic                                                        clk,
	input  wire logic                                                        reset_i,
	// replicated operation, one copy per replica
	input  wire logic [ft_alu_pkg::NUM_REPLICAS-1:0]                         enable_i,
	input  wire ft_alu_pkg::alu_op_e [ft_alu_pkg::NUM_REPLICAS-1:0]          operator_i,
	input  wire logic [ft_alu_pkg::NUM_REPLICAS-1:0][ft_alu_pkg::DATA_W-1:0] operand_a_i,
	input  wire logic [ft_alu_pkg::NUM_REPLICAS-1:0][ft_alu_pkg::DATA_W-1:0] operand_b_i,
	// redundancy control
	input  wire logic [ft_alu_pkg::NUM_LANES-1:0]                            sel_mux_i,
	input  wire logic                                                        only_two_i,
	input  wire logic [1:0]                                                  sel_only_two_i,
	input  wire ft_alu_pkg::bypass_e                                         sel_bypass_i,
	// results
	output logic      [ft_alu_pkg::DATA_W-1:0]                               result_o,
	output logic                                                             comparison_result_o,
	output logic                                                             err_detected_o,
	output logic                                                             err_corrected_o,
	output logic      [ft_alu_pkg::NUM_REPLICAS-1:0]                         permanent_faulty_o,
	// APB
	input  wire logic                                                        psel_i,
	input  wire logic                                                        penable_i,
	input  wire logic                                                        pwrite_i,
	input  wire logic [ft_alu_pkg::CSR_ADDR_W-1:0]                           paddr_i,
	input  wire logic [ft_alu_pkg::DATA_W-1:0]                               pwdata_i,
	output logic      [ft_alu_pkg::DATA_W-1:0]                               prdata_o
);
	import ft_alu_pkg::*;

	// replica outputs
	logic [NUM_REPLICAS-1:0][DATA_W-1:0] rep_result;
	logic [NUM_REPLICAS-1:0]             rep_comp;
	// voter lanes and their source replica
	logic [NUM_LANES-1:0][DATA_W-1:0]        lane_result;
	logic [NUM_LANES-1:0]                    lane_comp;
	logic [NUM_LANES-1:0][REPLICA_IDX_W-1:0] lane_src;
	// voter outputs
	logic [DATA_W-1:0]    result_voter;
	logic                 comp_voter;
	logic [NUM_LANES-1:0] err_lane_res;
	logic [NUM_LANES-1:0] err_lane_comp;
	logic                 err_corrected_res;
	logic                 err_corrected_comp;
	logic                 err_detected_res;
	logic                 err_detected_comp;
	// monitor and CSR
	logic [NUM_REPLICAS-1:0][CNT_W-1:0] err_count;
	logic [NUM_REPLICAS-1:0]            clr;

	////////////////////
	// replicas
	////////////////////

	for (genvar r = 0; r < NUM_REPLICAS; r++) begin : g_replica
		alu_replica alu_replica_inst (
			.enable_i            (enable_i[r]),
			.operator_i          (operator_i[r]),
			.operand_a_i         (operand_a_i[r]),
			.operand_b_i         (operand_b_i[r]),
			.result_o            (rep_result[r]),
			.comparison_result_o (rep_comp[r])
		);
	end

	lane_select lane_select_inst (
		.rep_result_i   (rep_result),
		.rep_comp_i     (rep_comp),
		.sel_mux_i      (sel_mux_i),
		.sel_only_two_i (sel_only_two_i),
		.lane_result_o  (lane_result),
		.lane_comp_o    (lane_comp),
		.lane_src_o     (lane_src)
	);

	////////////////////
	// voting
	////////////////////

	// result voter
	tmr_voter #(.WIDTH(DATA_W)) voter_res_inst (
		.in_1_i          (lane_result[0]),
		.in_2_i          (lane_result[1]),
		.in_3_i          (lane_result[2]),
		.only_two_i      (only_two_i),
		.voted_o         (result_voter),
		.err_lane_o      (err_lane_res),
		.err_corrected_o (err_corrected_res),
		.err_detected_o  (err_detected_res)
	);

	// comparison bit voter
	tmr_voter #(.WIDTH(1)) voter_comp_inst (
		.in_1_i          (lane_comp[0]),
		.in_2_i          (lane_comp[1]),
		.in_3_i          (lane_comp[2]),
		.only_two_i      (only_two_i),
		.voted_o         (comp_voter),
		.err_lane_o      (err_lane_comp),
		.err_corrected_o (err_corrected_comp),
		.err_detected_o  (err_detected_comp)
	);

	// flags always from the voters, even in bypass
	assign err_detected_o  = err_detected_res | err_detected_comp;
	assign err_corrected_o = err_corrected_res | err_corrected_comp;

	// bypass, a raw lane skips the vote
	always_comb begin
		result_o = result_voter;
		comparison_result_o = comp_voter;
		case (sel_bypass_i)
			BYP_VOTED: begin
				result_o = result_voter;
				comparison_result_o = comp_voter;
			end
			BYP_LANE1: begin
				result_o = lane_result[0];
				comparison_result_o = lane_comp[0];
			end
			BYP_LANE2: begin
				result_o = lane_result[1];
				comparison_result_o = lane_comp[1];
			end
			BYP_LANE3: begin
				result_o = lane_result[2];
				comparison_result_o = lane_comp[2];
			end
			default: begin
				result_o = result_voter;
			end
		endcase
	end

	////////////////////
	// fault tracking
	////////////////////

	fault_monitor fault_monitor_inst (
		.clk                (clk),
		.reset_i            (reset_i),
		.enable_i           (enable_i),
		.err_lane_res_i     (err_lane_res),
		.err_lane_comp_i    (err_lane_comp),
		.lane_src_i         (lane_src),
		.clr_i              (clr),
		.err_count_o        (err_count),
		.permanent_faulty_o (permanent_faulty_o)
	);

	ft_csr_apb ft_csr_apb_inst (
		.clk                (clk),
		.reset_i            (reset_i),
		.psel_i             (psel_i),
		.penable_i          (penable_i),
		.pwrite_i           (pwrite_i),
		.paddr_i            (paddr_i),
		.pwdata_i           (pwdata_i),
		.prdata_o           (prdata_o),
		.err_count_i        (err_count),
		.permanent_faulty_i (permanent_faulty_o),
		.clr_o              (clr)
	);

endmodule : ft_alu_top

`default_nettype wire

//--- verification/ft_alu_checker.sv
/*
 * result checker for the fault-tolerant ALU
 * samples DUT outputs at the falling edge and counts mismatches
 */
`timescale 1ns/100ps
`default_nettype none

module ft_alu_checker (
	input  wire logic                                clk,
	// DUT outputs under watch
	input  wire logic [ft_alu_pkg::DATA_W-1:0]       result_i,
	input  wire logic                                comparison_result_i,
	input  wire logic                                err_detected_i,
	input  wire logic                                err_corrected_i,
	input  wire logic [ft_alu_pkg::NUM_REPLICAS-1:0] permanent_faulty_i,
	input  wire logic [ft_alu_pkg::DATA_W-1:0]       prdata_i,
	input  wire logic                                psel_i,
	input  wire logic                                penable_i,
	input  wire logic                                pwrite_i,
	// expected values from the stimulus side
	input  wire logic                                check_alu_i,
	input  wire logic [ft_alu_pkg::DATA_W-1:0]       exp_result_i,
	input  wire logic                                exp_comp_i,
	input  wire logic                                exp_det_i,
	input  wire logic                                exp_cor_i,
	input  wire logic [ft_alu_pkg::NUM_REPLICAS-1:0] exp_perm_i,
	input  wire logic                                check_rd_i,
	input  wire logic [ft_alu_pkg::DATA_W-1:0]       exp_prdata_i,
	output int                                       error_count_o
);
	import ft_alu_pkg::*;

	initial begin
		error_count_o = 0;
	end

	// one line per wrong value, expected first
	task automatic report_mismatch(input string name, input logic [DATA_W-1:0] exp_val,
			input logic [DATA_W-1:0] act_val);
		error_count_o++;
		$display("Fail %s expected %h got %h at %0t", name, exp_val, act_val, $time);
	endtask

	////////////////////
	// sampling
	////////////////////

	// inputs move 2 ns after the rising edge, so mid-cycle is settled
	always @(negedge clk) begin
		if (check_alu_i) begin
			if (result_i !== exp_result_i) begin
				report_mismatch("result_o", exp_result_i, result_i);
			end
			if (comparison_result_i !== exp_comp_i) begin
				report_mismatch("comparison_result_o", DATA_W'(exp_comp_i),
					DATA_W'(comparison_result_i));
			end
			if (err_detected_i !== exp_det_i) begin
				report_mismatch("err_detected_o", DATA_W'(exp_det_i), DATA_W'(err_detected_i));
			end
			if (err_corrected_i !== exp_cor_i) begin
				report_mismatch("err_corrected_o", DATA_W'(exp_cor_i), DATA_W'(err_corrected_i));
			end
		end
		// sticky flags are watched whenever an operation or a read is live
		if (check_alu_i || check_rd_i) begin
			if (permanent_faulty_i !== exp_perm_i) begin
				report_mismatch("permanent_faulty_o", DATA_W'(exp_perm_i),
					DATA_W'(permanent_faulty_i));
			end
		end
		// read data only counts in the APB access phase
		if (check_rd_i && psel_i && penable_i && !pwrite_i) begin
			if (prdata_i !== exp_prdata_i) begin
				report_mismatch("prdata_o", exp_prdata_i, prdata_i);
			end
		end
	end

endmodule : ft_alu_checker

`default_nettype wire

//--- verification/ft_alu_tb.sv
/*
 * testbench for the fault-tolerant ALU
 * table driven vectors with injected replica faults, APB counter access
 */
`timescale 1ns/100ps
`default_nettype none

module ft_alu_tb;
	import ft_alu_pkg::*;

	localparam int NUM_VEC = 24;

	logic clk;
	logic reset_i;
	logic [NUM_REPLICAS-1:0] enable_i;
	alu_op_e [NUM_REPLICAS-1:0] operator_i;
	logic [NUM_REPLICAS-1:0][DATA_W-1:0] operand_a_i;
	logic [NUM_REPLICAS-1:0][DATA_W-1:0] operand_b_i;
	logic [NUM_LANES-1:0] sel_mux_i;
	logic only_two_i;
	logic [1:0] sel_only_two_i;
	bypass_e sel_bypass_i;
	logic [DATA_W-1:0] result_o;
	logic comparison_result_o;
	logic err_detected_o;
	logic err_corrected_o;
	logic [NUM_REPLICAS-1:0] permanent_faulty_o;
	logic psel_i;
	logic penable_i;
	logic pwrite_i;
	logic [CSR_ADDR_W-1:0] paddr_i;
	logic [DATA_W-1:0] pwdata_i;
	logic [DATA_W-1:0] prdata_o;
	// expected values handed to the checker
	logic check_alu;
	logic [DATA_W-1:0] exp_result;
	logic exp_comp;
	logic exp_det;
	logic exp_cor;
	logic [NUM_REPLICAS-1:0] exp_perm;
	logic check_rd;
	logic [DATA_W-1:0] exp_prdata;
	int error_count;
	logic [15:0] lfsr_state;

	// vector table
	alu_op_e vec_op[NUM_VEC];
	logic [DATA_W-1:0] vec_a[NUM_VEC];
	logic [DATA_W-1:0] vec_b[NUM_VEC];
	logic [NUM_REPLICAS-1:0] vec_mask[NUM_VEC];
	logic [DATA_W-1:0] vec_xor[NUM_VEC];
	logic [NUM_LANES-1:0] vec_mux[NUM_VEC];
	logic vec_two[NUM_VEC];
	logic [1:0] vec_sel_two[NUM_VEC];
	bypass_e vec_byp[NUM_VEC];
	logic [DATA_W-1:0] vec_exp_res[NUM_VEC];
	logic vec_exp_comp[NUM_VEC];
	logic vec_exp_det[NUM_VEC];
	logic vec_exp_cor[NUM_VEC];

	ft_alu_top ft_alu_top_inst (.*);

	ft_alu_checker ft_alu_checker_inst (
		.clk                 (clk),
		.result_i            (result_o),
		.comparison_result_i (comparison_result_o),
		.err_detected_i      (err_detected_o),
		.err_corrected_i     (err_corrected_o),
		.permanent_faulty_i  (permanent_faulty_o),
		.prdata_i            (prdata_o),
		.psel_i              (psel_i),
		.penable_i           (penable_i),
		.pwrite_i            (pwrite_i),
		.check_alu_i         (check_alu),
		.exp_result_i        (exp_result),
		.exp_comp_i          (exp_comp),
		.exp_det_i           (exp_det),
		.exp_cor_i           (exp_cor),
		.exp_perm_i          (exp_perm),
		.check_rd_i          (check_rd),
		.exp_prdata_i        (exp_prdata),
		.error_count_o       (error_count)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	////////////////////
	// reference model
	////////////////////

	// Fibonacci LFSR, taps 16 14 13 11, one step per bit
	function automatic logic [DATA_W-1:0] next_rand32();
		logic [DATA_W-1:0] val;
		logic fb;
		for (int i = 0; i < DATA_W; i++) begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			val = {val[DATA_W-2:0], fb};
		end
		return val;
	endfunction

	// {comparison bit, result} of one ALU operation
	function automatic logic [DATA_W:0] ref_alu(alu_op_e op, logic [DATA_W-1:0] a,
			logic [DATA_W-1:0] b);
		logic [DATA_W-1:0] res;
		logic cmp;
		res = '0;
		cmp = 1'b0;
		case (op)
			ADD: res = a + b;
			SUB: res = a - b;
			AND: res = a & b;
			OR: res = a | b;
			XOR: res = a ^ b;
			SLL: res = a << b[4:0];
			SRL: res = a >> b[4:0];
			SRA: res = $signed(a) >>> b[4:0];
			SLT: cmp = $signed(a) < $signed(b);
			SLTU: cmp = a < b;
			EQ: cmp = a == b;
			NE: cmp = a != b;
			default: res = '0;
		endcase
		// compares come back zero-extended
		if (op inside {SLT, SLTU, EQ, NE}) begin
			res = DATA_W'(cmp);
		end
		return {cmp, res};
	endfunction

	// {detected, corrected, value} following the voter rules
	function automatic logic [DATA_W+1:0] vote(logic [DATA_W-1:0] v1, logic [DATA_W-1:0] v2,
			logic [DATA_W-1:0] v3, logic two);
		if (two) begin
			return {v1 != v2, 1'b0, v1};
		end
		if (v1 == v2 && v1 == v3) begin
			return {2'b00, v1};
		end
		if (v1 == v2 || v1 == v3) begin
			return {2'b11, v1};
		end
		if (v2 == v3) begin
			return {2'b11, v2};
		end
		// no majority, lane 1 goes out uncorrected
		return {2'b10, v1};
	endfunction

	// expected outputs of one table entry
	function automatic void model_expected(int i);
		logic [NUM_REPLICAS-1:0][DATA_W:0] rv;
		int src[NUM_LANES];
		logic [DATA_W+1:0] vr;
		logic [DATA_W+1:0] vc;
		for (int r = 0; r < NUM_REPLICAS; r++) begin
			rv[r] = ref_alu(vec_op[i], vec_a[i] ^ (vec_mask[i][r] ? vec_xor[i] : '0), vec_b[i]);
		end
		for (int k = 0; k < NUM_LANES; k++) begin
			src[k] = vec_mux[i][k] ? NUM_REPLICAS - 1 : k;
		end
		// lanes 1 and 2 may be fed from lane 3
		for (int k = 0; k < 2; k++) begin
			if (vec_sel_two[i][k]) begin
				src[k] = src[2];
			end
		end
		vr = vote(rv[src[0]][DATA_W-1:0], rv[src[1]][DATA_W-1:0], rv[src[2]][DATA_W-1:0],
			vec_two[i]);
		vc = vote(DATA_W'(rv[src[0]][DATA_W]), DATA_W'(rv[src[1]][DATA_W]),
			DATA_W'(rv[src[2]][DATA_W]), vec_two[i]);
		vec_exp_det[i] = vr[DATA_W+1] | vc[DATA_W+1];
		vec_exp_cor[i] = vr[DATA_W] | vc[DATA_W];
		vec_exp_res[i] = vr[DATA_W-1:0];
		vec_exp_comp[i] = vc[0];
		if (vec_byp[i] != BYP_VOTED) begin
			vec_exp_res[i] = rv[src[int'(vec_byp[i]) - 1]][DATA_W-1:0];
			vec_exp_comp[i] = rv[src[int'(vec_byp[i]) - 1]][DATA_W];
		end
	endfunction

	task automatic set_vec(input int i, input alu_op_e op, input logic [3:0] mask,
			input logic [DATA_W-1:0] xv, input logic [2:0] mux, input logic two,
			input logic [1:0] sel_two, input bypass_e byp);
		vec_op[i] = op;
		vec_a[i] = next_rand32();
		vec_b[i] = next_rand32();
		vec_mask[i] = mask;
		vec_xor[i] = xv;
		vec_mux[i] = mux;
		vec_two[i] = two;
		vec_sel_two[i] = sel_two;
		vec_byp[i] = byp;
		model_expected(i);
	endtask

	task automatic build_table();
		// every opcode on clean replicas
		for (int i = 0; i < 12; i++) begin
			set_vec(i, alu_op_e'(i), 4'b0000, '0, 3'b000, 1'b0, 2'b00, BYP_VOTED);
		end
		// single corrupted replica, voted out
		set_vec(12, ADD, 4'b0001, 32'h1, 3'b000, 1'b0, 2'b00, BYP_VOTED);
		set_vec(13, SUB, 4'b0010, 32'h100, 3'b000, 1'b0, 2'b00, BYP_VOTED);
		set_vec(14, XOR, 4'b0100, 32'h8000_0000, 3'b000, 1'b0, 2'b00, BYP_VOTED);
		// spare corrupted, unused then used
		set_vec(15, ADD, 4'b1000, 32'h10, 3'b000, 1'b0, 2'b00, BYP_VOTED);
		set_vec(16, ADD, 4'b1000, 32'h10, 3'b001, 1'b0, 2'b00, BYP_VOTED);
		// only-two compares
		set_vec(17, ADD, 4'b0010, 32'h4, 3'b000, 1'b1, 2'b00, BYP_VOTED);
		set_vec(18, ADD, 4'b0001, 32'h4, 3'b000, 1'b1, 2'b00, BYP_VOTED);
		set_vec(19, ADD, 4'b0100, 32'h4, 3'b000, 1'b1, 2'b00, BYP_VOTED);
		// raw lanes through the bypass
		set_vec(20, ADD, 4'b0010, 32'h20, 3'b000, 1'b0, 2'b00, BYP_LANE1);
		set_vec(21, ADD, 4'b0010, 32'h20, 3'b000, 1'b0, 2'b00, BYP_LANE2);
		set_vec(22, ADD, 4'b0100, 32'h20, 3'b000, 1'b0, 2'b00, BYP_LANE3);
		set_vec(23, ADD, 4'b0001, 32'h20, 3'b001, 1'b0, 2'b00, BYP_LANE1);
	endtask

	////////////////////
	// drivers
	////////////////////

	// one enabled cycle, entered and left 2 ns after a rising edge
	task automatic apply_vec(input int i);
		for (int r = 0; r < NUM_REPLICAS; r++) begin
			operator_i[r] = vec_op[i];
			operand_a_i[r] = vec_a[i] ^ (vec_mask[i][r] ? vec_xor[i] : '0);
			operand_b_i[r] = vec_b[i];
		end
		enable_i = '1;
		sel_mux_i = vec_mux[i];
		only_two_i = vec_two[i];
		sel_only_two_i = vec_sel_two[i];
		sel_bypass_i = vec_byp[i];
		exp_result = vec_exp_res[i];
		exp_comp = vec_exp_comp[i];
		exp_det = vec_exp_det[i];
		exp_cor = vec_exp_cor[i];
		check_alu = 1'b1;
		@(posedge clk);
		#2;
		enable_i = '0;
		check_alu = 1'b0;
	endtask

	// setup then access, zero wait states so the access phase is one cycle
	task automatic apb_transfer(input logic wr, input logic [CSR_ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] expected);
		psel_i = 1'b1;
		penable_i = 1'b0;
		pwrite_i = wr;
		paddr_i = addr;
		pwdata_i = next_rand32();
		@(posedge clk);
		#2;
		penable_i = 1'b1;
		exp_prdata = expected;
		check_rd = !wr;
		@(posedge clk);
		#2;
		psel_i = 1'b0;
		penable_i = 1'b0;
		check_rd = 1'b0;
	endtask

	initial begin
		lfsr_state = 16'd55421;
		reset_i = 1'b1;
		enable_i = '0;
		for (int r = 0; r < NUM_REPLICAS; r++) begin
			operator_i[r] = ADD;
		end
		operand_a_i = '0;
		operand_b_i = '0;
		sel_mux_i = '0;
		only_two_i = 1'b0;
		sel_only_two_i = '0;
		sel_bypass_i = BYP_VOTED;
		{psel_i, penable_i, pwrite_i, paddr_i, pwdata_i} = '0;
		{check_alu, exp_result, exp_comp, exp_det, exp_cor, check_rd, exp_prdata} = '0;
		exp_perm = '0;
		build_table();
		repeat (16) @(posedge clk);
		#2;
		reset_i = 1'b0;
		for (int i = 0; i < NUM_VEC; i++) begin
			apply_vec(i);
		end
		// start the count test from zero on every replica
		for (int r = 0; r < NUM_REPLICAS; r++) begin
			apb_transfer(1'b1, CSR_CNT0_ADDR + CSR_ADDR_W'(4 * r), '0);
			apb_transfer(1'b0, CSR_CNT0_ADDR + CSR_ADDR_W'(4 * r), '0);
		end
		// entry 14 blames replica 2 on every cycle
		repeat (7) apply_vec(14);
		apb_transfer(1'b0, CSR_CNT2_ADDR, 32'd7);
		apb_transfer(1'b0, CSR_STATUS_ADDR, 32'h0);
		apply_vec(14);
		// eighth error sets the sticky flag of replica 2
		exp_perm = 4'b0100;
		apb_transfer(1'b0, CSR_CNT2_ADDR, 32'd8);
		apb_transfer(1'b0, CSR_STATUS_ADDR, 32'h4);
		repeat (252) apply_vec(14);
		apb_transfer(1'b0, CSR_CNT2_ADDR, 32'd255);
		apb_transfer(1'b0, CSR_STATUS_ADDR, 32'h4);
		apb_transfer(1'b0, CSR_CNT0_ADDR, 32'd0);
		apb_transfer(1'b0, CSR_CNT1_ADDR, 32'd0);
		apb_transfer(1'b0, CSR_CNT3_ADDR, 32'd0);
		// write clears counter and flag
		apb_transfer(1'b1, CSR_CNT2_ADDR, '0);
		exp_perm = '0;
		apb_transfer(1'b0, CSR_CNT2_ADDR, 32'd0);
		apb_transfer(1'b0, CSR_STATUS_ADDR, 32'h0);
		apb_transfer(1'b0, 12'h014, 32'h0);
		apb_transfer(1'b0, 12'h020, 32'h0);
		repeat (2) @(posedge clk);
		$display("mismatches %0d", error_count);
		if (error_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule : ft_alu_tb

`default_nettype wire

//--- build.f
source/ft_alu_pkg.sv
source/alu_replica.sv
source/lane_select.sv
source/tmr_voter.sv
source/fault_monitor.sv
source/ft_csr_apb.sv
source/ft_alu_top.sv
verification/ft_alu_checker.sv
verification/ft_alu_tb.sv
